// File: common/decode_pkg.sv
package decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;

    // major opcodes, inst[31:26]
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes, inst[5:0]
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    localparam logic [4:0] rt_bltz = 5'h00; // regimm selector in rt
    localparam logic [4:0] rt_bgez = 5'h01;

    // bit positions in the one-hot alu_op
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_bus_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } rf_write_t;

    // result report from es, ms or ws
    typedef struct packed {
        logic                  valid;
        logic                  gr_we;
        logic                  is_load; // value not there yet
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       value;
    } fwd_bus_t;

    typedef struct packed {
        logic [alu_op_w-1:0]   alu_op;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  src2_is_8;
        logic                  zero_ext_imm;
        logic                  load_op;
        logic                  mem_we;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [15:0]           imm;
    } ctrl_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [xlen-1:0] rs_value;
        logic [xlen-1:0] rt_value;
        logic [xlen-1:0] pc;
    } decode_bus_t;

    typedef struct packed {
        logic            stall;
        logic            taken;
        logic [xlen-1:0] target;
    } branch_bus_t;

endpackage

// File: rtl/regfile.sv
module regfile (
    input  logic                              clk,
    input  logic [decode_pkg::reg_addr_w-1:0] raddr1,
    input  logic [decode_pkg::reg_addr_w-1:0] raddr2,
    output logic [decode_pkg::xlen-1:0]       rdata1,
    output logic [decode_pkg::xlen-1:0]       rdata2,
    input  decode_pkg::rf_write_t             wr
);

    logic [decode_pkg::xlen-1:0] regs [0:(1 << decode_pkg::reg_addr_w)-1];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            regs[wr.waddr] <= wr.wdata; // r0 may be written, never read back
        end
    end

    // combinational read, r0 hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    write_addr_known: assert property (@(posedge clk)
        wr.we |-> !$isunknown(wr.waddr));

endmodule

// File: decode/instr_decoder.sv
module instr_decoder (
    input  logic [decode_pkg::xlen-1:0] inst,
    output decode_pkg::ctrl_t           ctrl,
    output logic                        is_beq,
    output logic                        is_bne,
    output logic                        is_bgez,
    output logic                        is_bltz,
    output logic                        is_jump,
    output logic                        is_jr
);

    logic [5:0] op;
    logic [5:0] func;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic       special;
    logic       inst_addu, inst_subu, inst_slt, inst_sltu;
    logic       inst_and, inst_or, inst_xor, inst_nor;
    logic       inst_sll, inst_srl, inst_sra;
    logic       inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic       inst_lw, inst_sw, inst_jal;
    logic       dst_is_rt;
    logic       known;

    assign op      = inst[31:26];
    assign rs      = inst[25:21];
    assign rt      = inst[20:16];
    assign rd      = inst[15:11];
    assign sa      = inst[10:6];
    assign func    = inst[5:0];
    assign special = (op == decode_pkg::op_special);

    // register-register ops need sa clear
    assign inst_addu = special && func == decode_pkg::fn_addu && sa == '0;
    assign inst_subu = special && func == decode_pkg::fn_subu && sa == '0;
    assign inst_slt  = special && func == decode_pkg::fn_slt  && sa == '0;
    assign inst_sltu = special && func == decode_pkg::fn_sltu && sa == '0;
    assign inst_and  = special && func == decode_pkg::fn_and  && sa == '0;
    assign inst_or   = special && func == decode_pkg::fn_or   && sa == '0;
    assign inst_xor  = special && func == decode_pkg::fn_xor  && sa == '0;
    assign inst_nor  = special && func == decode_pkg::fn_nor  && sa == '0;
    assign inst_sll  = special && func == decode_pkg::fn_sll  && rs == '0; // shift by sa
    assign inst_srl  = special && func == decode_pkg::fn_srl  && rs == '0;
    assign inst_sra  = special && func == decode_pkg::fn_sra  && rs == '0;
    assign is_jr     = special && func == decode_pkg::fn_jr && rt == '0 && rd == '0 && sa == '0;

    assign inst_addiu = (op == decode_pkg::op_addiu);
    assign inst_slti  = (op == decode_pkg::op_slti);
    assign inst_sltiu = (op == decode_pkg::op_sltiu);
    assign inst_andi  = (op == decode_pkg::op_andi);
    assign inst_ori   = (op == decode_pkg::op_ori);
    assign inst_xori  = (op == decode_pkg::op_xori);
    assign inst_lui   = (op == decode_pkg::op_lui) && rs == '0;
    assign inst_lw    = (op == decode_pkg::op_lw);
    assign inst_sw    = (op == decode_pkg::op_sw);
    assign inst_jal   = (op == decode_pkg::op_jal);
    assign is_beq     = (op == decode_pkg::op_beq);
    assign is_bne     = (op == decode_pkg::op_bne);
    assign is_bgez    = (op == decode_pkg::op_regimm) && rt == decode_pkg::rt_bgez;
    assign is_bltz    = (op == decode_pkg::op_regimm) && rt == decode_pkg::rt_bltz;
    assign is_jump    = (op == decode_pkg::op_j) || inst_jal;

    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                     | inst_xori | inst_lui | inst_lw;

    assign known = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                 | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra | dst_is_rt
                 | inst_sw | is_beq | is_bne | is_bgez | is_bltz | is_jump | is_jr;

    always_comb begin
        ctrl = '0; // anything unrecognised stays a bubble
        ctrl.alu_op[decode_pkg::alu_add]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
        ctrl.alu_op[decode_pkg::alu_sub]  = inst_subu;
        ctrl.alu_op[decode_pkg::alu_slt]  = inst_slt  | inst_slti;
        ctrl.alu_op[decode_pkg::alu_sltu] = inst_sltu | inst_sltiu;
        ctrl.alu_op[decode_pkg::alu_and]  = inst_and  | inst_andi;
        ctrl.alu_op[decode_pkg::alu_nor]  = inst_nor;
        ctrl.alu_op[decode_pkg::alu_or]   = inst_or   | inst_ori;
        ctrl.alu_op[decode_pkg::alu_xor]  = inst_xor  | inst_xori;
        ctrl.alu_op[decode_pkg::alu_sll]  = inst_sll;
        ctrl.alu_op[decode_pkg::alu_srl]  = inst_srl;
        ctrl.alu_op[decode_pkg::alu_sra]  = inst_sra;
        ctrl.alu_op[decode_pkg::alu_lui]  = inst_lui;
        ctrl.src1_is_sa   = inst_sll | inst_srl | inst_sra;
        ctrl.src1_is_pc   = inst_jal; // link value is pc + 8
        ctrl.src2_is_8    = inst_jal;
        ctrl.src2_is_imm  = dst_is_rt | inst_sw;
        ctrl.zero_ext_imm = inst_andi | inst_ori | inst_xori;
        ctrl.load_op      = inst_lw;
        ctrl.mem_we       = inst_sw;
        ctrl.gr_we        = |ctrl.alu_op & ~inst_sw;
        if (known) begin
            ctrl.dest = inst_jal ? 5'd31 : (dst_is_rt ? rt : rd);
            ctrl.imm  = inst[15:0];
        end
    end

    always_comb begin
        alu_op_onehot: assert ($onehot0(ctrl.alu_op));
    end

endmodule

// File: decode/operand_forward.sv
module operand_forward (
    input  logic [decode_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [decode_pkg::reg_addr_w-1:0] rt_addr,
    input  logic [decode_pkg::xlen-1:0]       rf_rs,
    input  logic [decode_pkg::xlen-1:0]       rf_rt,
    input  decode_pkg::fwd_bus_t              es_fw,
    input  decode_pkg::fwd_bus_t              ms_fw,
    input  decode_pkg::fwd_bus_t              ws_fw,
    output logic [decode_pkg::xlen-1:0]       rs_value,
    output logic [decode_pkg::xlen-1:0]       rt_value,
    output logic                              load_hazard
);

    // youngest producer first, then the register file
    function automatic logic [decode_pkg::xlen-1:0] pick(
        input logic [decode_pkg::reg_addr_w-1:0] addr,
        input logic [decode_pkg::xlen-1:0]       rf_value,
        input decode_pkg::fwd_bus_t              es,
        input decode_pkg::fwd_bus_t              ms,
        input decode_pkg::fwd_bus_t              ws
    );
        logic [decode_pkg::xlen-1:0] result;
        if (addr == '0) begin
            result = '0;
        end else if (es.valid && es.gr_we && !es.is_load && es.addr == addr) begin
            result = es.value;
        end else if (ms.valid && ms.gr_we && ms.addr == addr) begin
            result = ms.value;
        end else if (ws.valid && ws.gr_we && ws.addr == addr) begin
            result = ws.value;
        end else begin
            result = rf_value;
        end
        return result;
    endfunction

    assign rs_value = pick(rs_addr, rf_rs, es_fw, ms_fw, ws_fw);
    assign rt_value = pick(rt_addr, rf_rt, es_fw, ms_fw, ws_fw);

    // load in execute has no data until memory
    assign load_hazard = es_fw.valid && es_fw.is_load
                      && ((rs_addr != '0 && es_fw.addr == rs_addr)
                      ||  (rt_addr != '0 && es_fw.addr == rt_addr));

endmodule

// File: decode/branch_unit.sv
module branch_unit (
    input  logic [decode_pkg::xlen-1:0] pc,
    input  logic [decode_pkg::xlen-1:0] inst,
    input  logic [decode_pkg::xlen-1:0] rs_value,
    input  logic [decode_pkg::xlen-1:0] rt_value,
    input  logic                        is_beq,
    input  logic                        is_bne,
    input  logic                        is_bgez,
    input  logic                        is_bltz,
    input  logic                        is_jump,
    input  logic                        is_jr,
    input  logic                        ready,
    output logic                        taken,
    output logic [decode_pkg::xlen-1:0] target
);

    logic [decode_pkg::xlen-1:0] pc_plus4;
    logic [decode_pkg::xlen-1:0] br_offset;
    logic                        rs_eq_rt;
    logic                        rs_neg;
    logic                        cond;

    assign pc_plus4  = pc + 32'd4; // delay slot address
    assign br_offset = {{14{inst[15]}}, inst[15:0], 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);
    assign rs_neg    = rs_value[decode_pkg::xlen-1];

    assign cond = (is_beq  &&  rs_eq_rt)
               || (is_bne  && !rs_eq_rt)
               || (is_bgez && !rs_neg)
               || (is_bltz &&  rs_neg)
               || is_jump || is_jr;

    assign taken = ready && cond;

    always_comb begin
        if (is_jr) begin
            target = rs_value;
        end else if (is_jump) begin
            target = {pc_plus4[31:28], inst[25:0], 2'b00}; // same 256MB region
        end else begin
            target = pc_plus4 + br_offset;
        end
    end

endmodule

// File: rtl/id_stage.sv
module id_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fs_valid,
    input  decode_pkg::fetch_bus_t  fs_bus,
    output logic                    ds_allowin,
    input  logic                    es_allowin,
    output logic                    ds_to_es_valid,
    output decode_pkg::decode_bus_t ds_to_es_bus,
    output decode_pkg::branch_bus_t br_bus,
    input  decode_pkg::fwd_bus_t    es_fw,
    input  decode_pkg::fwd_bus_t    ms_fw,
    input  decode_pkg::fwd_bus_t    ws_fw,
    input  decode_pkg::rf_write_t   ws_rf
);

    decode_pkg::fetch_bus_t ds_bus_r; // held fetch item
    logic                   ds_valid;
    logic                   ds_ready_go;
    logic                   load_hazard;
    decode_pkg::ctrl_t      ctrl;
    logic                   is_beq;
    logic                   is_bne;
    logic                   is_bgez;
    logic                   is_bltz;
    logic                   is_jump;
    logic                   is_jr;
    logic [decode_pkg::reg_addr_w-1:0] rs_addr;
    logic [decode_pkg::reg_addr_w-1:0] rt_addr;
    logic [decode_pkg::xlen-1:0]       rf_rs;
    logic [decode_pkg::xlen-1:0]       rf_rt;
    logic [decode_pkg::xlen-1:0]       rs_value;
    logic [decode_pkg::xlen-1:0]       rt_value;

    assign rs_addr = ds_bus_r.inst[25:21];
    assign rt_addr = ds_bus_r.inst[20:16];

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_bus_r <= fs_bus;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    assign ds_ready_go    = !load_hazard;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    assign ds_to_es_bus = '{ctrl: ctrl, rs_value: rs_value, rt_value: rt_value, pc: ds_bus_r.pc};
    assign br_bus.stall = ds_valid && !ds_ready_go; // fetch waits for the operand

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs_addr),
        .raddr2 (rt_addr),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt),
        .wr     (ws_rf)
    );

    instr_decoder u_instr_decoder (
        .inst    (ds_bus_r.inst),
        .ctrl    (ctrl),
        .is_beq  (is_beq),
        .is_bne  (is_bne),
        .is_bgez (is_bgez),
        .is_bltz (is_bltz),
        .is_jump (is_jump),
        .is_jr   (is_jr)
    );

    operand_forward u_operand_forward (
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rf_rs       (rf_rs),
        .rf_rt       (rf_rt),
        .es_fw       (es_fw),
        .ms_fw       (ms_fw),
        .ws_fw       (ws_fw),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .load_hazard (load_hazard)
    );

    branch_unit u_branch_unit (
        .pc       (ds_bus_r.pc),
        .inst     (ds_bus_r.inst),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .is_beq   (is_beq),
        .is_bne   (is_bne),
        .is_bgez  (is_bgez),
        .is_bltz  (is_bltz),
        .is_jump  (is_jump),
        .is_jr    (is_jr),
        .ready    (ds_to_es_valid),
        .taken    (br_bus.taken),
        .target   (br_bus.target)
    );

    // execute stalled, so the offered bundle must not move
    hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> $stable(ds_to_es_bus));

    // fetch jumps to this address, so it must be resolved
    redirect_target_known: assert property (@(posedge clk) disable iff (reset)
        br_bus.taken |-> !$isunknown(br_bus.target));

endmodule

// File: dv/tb_id_stage.sv
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    logic                    clk;
    logic                    reset;
    logic                    fs_valid;
    decode_pkg::fetch_bus_t  fs_bus;
    logic                    ds_allowin;
    logic                    es_allowin;
    logic                    ds_to_es_valid;
    decode_pkg::decode_bus_t ds_to_es_bus;
    decode_pkg::branch_bus_t br_bus;
    decode_pkg::fwd_bus_t    es_fw;
    decode_pkg::fwd_bus_t    ms_fw;
    decode_pkg::fwd_bus_t    ws_fw;
    decode_pkg::rf_write_t   ws_rf;

    id_stage u_id_stage (
        .clk            (clk),
        .reset          (reset),
        .fs_valid       (fs_valid),
        .fs_bus         (fs_bus),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_bus         (br_bus),
        .es_fw          (es_fw),
        .ms_fw          (ms_fw),
        .ws_fw          (ws_fw),
        .ws_rf          (ws_rf)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_allowin();
        int cycles;
        cycles = 0;
        while (!ds_allowin) begin
            if (cycles == 20) begin
                stop_with("timeout: ds_allowin stayed low for 20 cycles");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        ws_rf <= '{we: 1'b1, waddr: addr, wdata: data};
        @(posedge clk); // register takes it here
        ws_rf.we <= 1'b0;
    endtask

    // I presents a new item, H only updates reports and es_allowin
    task automatic run_vector(input int fd, input logic is_new);
        logic [31:0] pc, inst, tgt, rsv, rtv;
        logic [39:0] es, ms, ws;
        logic        ea, ev, est, etk, eain;
        logic [11:0] aop;
        logic [7:0]  flg;
        logic [4:0]  dst;
        logic [15:0] imm;
        int          n;
        n = $fscanf(fd, "%h %h %h %h %h %h", pc, inst, es, ms, ws, ea);
        n += $fscanf(fd, "%h %h %h %h %h %h", ev, est, etk, tgt, aop, flg);
        n += $fscanf(fd, "%h %h %h %h %h", dst, imm, rsv, rtv, eain);
        if (n != 17) begin
            stop_with("golden file has a short vector line");
        end
        if (is_new) begin
            @(negedge clk);
            wait_allowin();
            @(posedge clk);
            fs_valid <= 1'b1;
            fs_bus   <= '{pc: pc, inst: inst};
        end
        @(posedge clk);
        if (is_new) begin
            fs_valid <= 1'b0; // accepted on this edge
        end
        es_fw      <= es;
        ms_fw      <= ms;
        ws_fw      <= ws;
        es_allowin <= ea;
        @(negedge clk);
        check_value("ds_to_es_valid", 64'(ev), 64'(ds_to_es_valid));
        check_value("br_bus.stall", 64'(est), 64'(br_bus.stall));
        check_value("br_bus.taken", 64'(etk), 64'(br_bus.taken));
        if (etk) begin
            check_value("br_bus.target", 64'(tgt), 64'(br_bus.target));
        end
        check_value("ds_allowin", 64'(eain), 64'(ds_allowin));
        check_value("ctrl.alu_op", 64'(aop), 64'(ds_to_es_bus.ctrl.alu_op));
        check_value("ctrl.flags", 64'(flg),
                    64'({ds_to_es_bus.ctrl.src1_is_sa, ds_to_es_bus.ctrl.src1_is_pc,
                         ds_to_es_bus.ctrl.src2_is_imm, ds_to_es_bus.ctrl.src2_is_8,
                         ds_to_es_bus.ctrl.zero_ext_imm, ds_to_es_bus.ctrl.load_op,
                         ds_to_es_bus.ctrl.mem_we, ds_to_es_bus.ctrl.gr_we}));
        check_value("ctrl.dest", 64'(dst), 64'(ds_to_es_bus.ctrl.dest));
        check_value("ctrl.imm", 64'(imm), 64'(ds_to_es_bus.ctrl.imm));
        check_value("rs_value", 64'(rsv), 64'(ds_to_es_bus.rs_value));
        check_value("rt_value", 64'(rtv), 64'(ds_to_es_bus.rt_value));
        check_value("pc", 64'(pc), 64'(ds_to_es_bus.pc));
    endtask

    initial begin
        int          fd;
        int          c;
        logic [7:0]  cmd;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic        done;
        fs_valid    = 1'b0;
        fs_bus      = '0;
        es_allowin  = 1'b1;
        es_fw       = '0;
        ms_fw       = '0;
        ws_fw       = '0;
        ws_rf       = '0;
        reset       = 1'b1;
        done        = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("ds_to_es_valid", 64'd0, 64'(ds_to_es_valid));
        check_value("br_bus.taken", 64'd0, 64'(br_bus.taken));
        check_value("br_bus.stall", 64'd0, 64'(br_bus.stall));
        check_value("ds_allowin", 64'd1, 64'(ds_allowin));
        fd = $fopen("dv/id_golden.txt", "r");
        if (fd == 0) begin
            stop_with("cannot open dv/id_golden.txt");
        end
        while (!done) begin
            if ($fscanf(fd, "%s", cmd) != 1) begin
                stop_with("golden file ended without an E line");
            end
            case (cmd)
                "#": begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end
                "W": begin
                    if ($fscanf(fd, "%h %h", waddr, wdata) != 2) begin
                        stop_with("golden file has a short W line");
                    end
                    write_reg(waddr, wdata);
                end
                "I": run_vector(fd, 1'b1);
                "H": run_vector(fd, 1'b0);
                "E": done = 1'b1;
                default: stop_with("golden file has an unknown command");
            endcase
        end
        $fclose(fd);
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        #400000;
        stop_with("timeout: whole run took too long");
    end

endmodule

// File: dv/id_golden.txt
# W addr data | I/H pc inst es_fw ms_fw ws_fw es_allowin | valid stall taken target
# alu_op flags(sa pc imm 8 zext load mwe gwe) dest imm rs_value rt_value ds_allowin | E ends
W 01 11111111
W 02 22222222
W 03 80000000
W 04 00001000
W 05 22222222
I 00400000 00223021 0000000000 0000000000 0000000000 1 1 0 0 00000000 001 01 06 3021 11111111 22222222 1
I 00400004 00013821 0000000000 0000000000 0000000000 1 1 0 0 00000000 001 01 07 3821 00000000 11111111 1
I 00400008 2422fffc 0000000000 0000000000 0000000000 1 1 0 0 00000000 001 21 02 fffc 11111111 22222222 1
I 0040000c 342300ff 0000000000 0000000000 0000000000 1 1 0 0 00000000 040 29 03 00ff 11111111 80000000 1
I 00400010 3c041234 0000000000 0000000000 0000000000 1 1 0 0 00000000 800 21 04 1234 00000000 00001000 1
I 00400014 8c250008 0000000000 0000000000 0000000000 1 1 0 0 00000000 001 25 05 0008 11111111 22222222 1
I 00400018 ac220004 0000000000 0000000000 0000000000 1 1 0 0 00000000 001 22 00 0004 11111111 22222222 1
I 0040001c 00023100 0000000000 0000000000 0000000000 1 1 0 0 00000000 100 81 06 3100 00000000 22222222 1
I 00400020 fc000000 0000000000 0000000000 0000000000 1 1 0 0 00000000 000 00 00 0000 00000000 00000000 1
I 00400024 00223021 C1aaaaaaaa C1bbbbbbbb C2cccccccc 1 1 0 0 00000000 001 01 06 3021 aaaaaaaa cccccccc 1
I 00400028 00223021 81aaaaaaaa C1bbbbbbbb C1cccccccc 1 1 0 0 00000000 001 01 06 3021 bbbbbbbb 22222222 1
I 0040002c 00023021 C0dddddddd 0000000000 C2cccccccc 1 1 0 0 00000000 001 01 06 3021 00000000 cccccccc 1
I 00400000 10450004 0000000000 0000000000 0000000000 1 1 0 1 00400014 000 00 00 0004 22222222 22222222 1
I 00400000 1422ffff 0000000000 0000000000 0000000000 1 1 0 1 00400000 000 00 1f ffff 11111111 22222222 1
I 00400000 14450004 0000000000 0000000000 0000000000 1 1 0 0 00000000 000 00 00 0004 22222222 22222222 1
I 00400000 04210008 0000000000 0000000000 0000000000 1 1 0 1 00400024 000 00 00 0008 11111111 11111111 1
I 00400000 04600010 0000000000 0000000000 0000000000 1 1 0 1 00400044 000 00 00 0010 80000000 00000000 1
I 10400000 08000040 0000000000 0000000000 0000000000 1 1 0 1 10000100 000 00 00 0040 00000000 00000000 1
I 10400000 0c000080 0000000000 0000000000 0000000000 1 1 0 1 10000200 001 51 1f 0080 00000000 00000000 1
I 00400000 00800008 0000000000 0000000000 0000000000 1 1 0 1 00001000 000 00 00 0008 00001000 00000000 1
I 00400030 00223021 E1aaaaaaaa C1bbbbbbbb 0000000000 1 0 1 0 00000000 001 01 06 3021 bbbbbbbb 22222222 0
H 00400030 00223021 0000000000 C1bbbbbbbb 0000000000 1 1 0 0 00000000 001 01 06 3021 bbbbbbbb 22222222 1
I 00400040 342300ff 0000000000 0000000000 0000000000 0 1 0 0 00000000 040 29 03 00ff 11111111 80000000 0
H 00400040 342300ff 0000000000 0000000000 0000000000 0 1 0 0 00000000 040 29 03 00ff 11111111 80000000 0
H 00400040 342300ff 0000000000 0000000000 0000000000 0 1 0 0 00000000 040 29 03 00ff 11111111 80000000 0
H 00400040 342300ff 0000000000 0000000000 0000000000 1 1 0 0 00000000 040 29 03 00ff 11111111 80000000 1
E

// File: compile.f
common/decode_pkg.sv
rtl/regfile.sv
decode/instr_decoder.sv
decode/operand_forward.sv
decode/branch_unit.sv
rtl/id_stage.sv
dv/tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_id_stage -f compile.f -o sim_tb_id_stage

# the log decides the result, so the exit code of the run is not used here
./obj_dir/sim_tb_id_stage > sim.log 2>&1 || true

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
echo "simulation passed"
